// ==== source/vec_sub_params.svh ====
`ifndef VEC_SUB_PARAMS_SVH
`define VEC_SUB_PARAMS_SVH

// bits in one signed lane.
`define VEC_LANE_WIDTH 32

// lanes in one vector, lane 0 in the low bits.
`define VEC_LANES 3

// entries in each FIFO, must be a power of two.
`define VEC_FIFO_DEPTH 16

`endif

// ==== source/vec_sub_pkg.sv ====
package vec_sub_pkg;

`include "vec_sub_params.svh"

    // one signed lane.
    // arithmetic on it wraps modulo 2^VEC_LANE_WIDTH.
    typedef logic signed [`VEC_LANE_WIDTH-1:0] lane_t;

    // a full vector of lanes.
    // lane 0 sits in the low bits, so element i is lane i.
    typedef lane_t [`VEC_LANES-1:0] vec3_t;

endpackage

// ==== source/operand_if.sv ====
interface operand_if;

    import vec_sub_pkg::*;

    // head pair of the operand FIFO, valid while empty is low.
    vec3_t x;
    vec3_t y;
    logic  empty;

    // one clock high pops the head pair.
    logic  rd_en;

    modport fifo_side (
        output x,
        output y,
        output empty,
        input  rd_en
    );

    modport stage_side (
        input  x,
        input  y,
        input  empty,
        output rd_en
    );

endinterface

// ==== source/show_ahead_fifo.sv ====
`include "vec_sub_params.svh"

module show_ahead_fifo #(
    parameter int width = 32
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             wr_en,
    input  logic [width-1:0] din,
    output logic             full,
    input  logic             rd_en,
    output logic [width-1:0] dout,
    output logic             empty
);

    localparam int depth      = `VEC_FIFO_DEPTH;
    localparam int addr_width = $clog2(depth);

    logic [width-1:0]      mem [depth];

    // pointers carry one wrap bit above the address.
    logic [addr_width:0]   wr_ptr;
    logic [addr_width:0]   rd_ptr;
    logic [addr_width-1:0] wr_addr;
    logic [addr_width-1:0] rd_addr;
    logic                  wr_wrap;
    logic                  rd_wrap;

    logic                  wr_accept;
    logic                  rd_accept;

    assign wr_addr = wr_ptr[addr_width-1:0];
    assign rd_addr = rd_ptr[addr_width-1:0];
    assign wr_wrap = wr_ptr[addr_width];
    assign rd_wrap = rd_ptr[addr_width];

    // same address on the same lap means empty.
    assign empty = (wr_addr == rd_addr) && (wr_wrap == rd_wrap);

    // same address one lap apart means full.
    assign full  = (wr_addr == rd_addr) && (wr_wrap != rd_wrap);

    // a write while full or a read while empty is dropped.
    assign wr_accept = wr_en && !full;
    assign rd_accept = rd_en && !empty;

    always_ff @(posedge clock) begin
        if (wr_accept) begin
            mem[wr_addr] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (wr_accept) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (rd_accept) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // head entry is visible without a read, so the consumer
    // samples it in the same cycle it pulses rd_en.
    assign dout = mem[rd_addr];

endmodule

// ==== source/vec_sub_stage.sv ====
`include "vec_sub_params.svh"

module vec_sub_stage (
    input  logic               clock,
    input  logic               reset,
    operand_if.stage_side      operands,
    output vec_sub_pkg::vec3_t diff,
    input  logic               full,
    output logic               wr_en
);

    import vec_sub_pkg::*;

    typedef enum logic {
        idle,
        hold
    } state_t;

    state_t state;
    state_t next_state;
    vec3_t  diff_r;
    vec3_t  diff_c;

    // lane-wise a - b, each lane wrapping on its own.
    function automatic vec3_t sub_lanes(input vec3_t a, input vec3_t b);
        vec3_t r;
        lane_t la;
        lane_t lb;
        for (int lane = 0; lane < `VEC_LANES; lane++) begin
            la      = a[lane];
            lb      = b[lane];
            r[lane] = la - lb;
        end
        return r;
    endfunction

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state  <= idle;
            diff_r <= '0;
        end else begin
            state  <= next_state;
            diff_r <= diff_c;
        end
    end

    always_comb begin
        next_state     = state;
        diff_c         = diff_r;
        operands.rd_en = 1'b0;
        wr_en          = 1'b0;

        case (state)
            idle: begin
                // head pair is sampled in the cycle it is popped.
                if (!operands.empty) begin
                    diff_c         = sub_lanes(operands.x, operands.y);
                    operands.rd_en = 1'b1;
                    next_state     = hold;
                end
            end

            hold: begin
                // result stays put until the result FIFO has room.
                if (!full) begin
                    wr_en      = 1'b1;
                    next_state = idle;
                end
            end

            default: begin
                next_state = idle;
            end
        endcase
    end

    assign diff = diff_r;

endmodule

// ==== source/vec_sub_top.sv ====
`include "vec_sub_params.svh"

module vec_sub_top (
    input  logic               clock,
    input  logic               reset,
    input  vec_sub_pkg::vec3_t in_x,
    input  vec_sub_pkg::vec3_t in_y,
    input  logic               in_wr_en,
    output logic               in_full,
    output vec_sub_pkg::vec3_t out_diff,
    output logic               out_empty,
    input  logic               out_rd_en
);

    import vec_sub_pkg::*;

    localparam int vec_width = `VEC_LANE_WIDTH * `VEC_LANES;

    // operand word holds x in the upper half and y in the lower.
    logic [2*vec_width-1:0] operand_din;
    logic [2*vec_width-1:0] operand_dout;

    vec3_t diff;
    logic  diff_wr_en;
    logic  result_full;

    operand_if operands ();

    assign operand_din = {in_x, in_y};

    assign operands.x = operand_dout[2*vec_width-1:vec_width];
    assign operands.y = operand_dout[vec_width-1:0];

    show_ahead_fifo #(
        .width (2 * vec_width)
    ) operand_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (in_wr_en),
        .din   (operand_din),
        .full  (in_full),
        .rd_en (operands.rd_en),
        .dout  (operand_dout),
        .empty (operands.empty)
    );

    vec_sub_stage sub_stage (
        .clock    (clock),
        .reset    (reset),
        .operands (operands.stage_side),
        .diff     (diff),
        .full     (result_full),
        .wr_en    (diff_wr_en)
    );

    show_ahead_fifo #(
        .width (vec_width)
    ) result_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (diff_wr_en),
        .din   (diff),
        .full  (result_full),
        .rd_en (out_rd_en),
        .dout  (out_diff),
        .empty (out_empty)
    );

endmodule

// ==== bench/vec_sub_tb.sv ====
`include "vec_sub_params.svh"

module vec_sub_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import vec_sub_pkg::*;

    localparam int fill_count    = 2 * `VEC_FIFO_DEPTH + 1;
    localparam int stream_count  = 200;
    localparam int total_vectors = 1 + 2 + stream_count + fill_count + 4;
    localparam int limit_cycles  = total_vectors * 4 + 2000;
    localparam int drain_limit   = 4 * fill_count + 100;

    logic  clock;
    logic  reset;
    vec3_t in_x;
    vec3_t in_y;
    logic  in_wr_en;
    logic  in_full;
    vec3_t out_diff;
    logic  out_empty;
    logic  out_rd_en;

    integer seed;
    int     errors;
    int     checks;
    int     tests;
    int     test_mark;
    vec3_t  expected[$];
    vec3_t  head_v;

    vec_sub_top vec_sub_top_i (
        .clock     (clock),
        .reset     (reset),
        .in_x      (in_x),
        .in_y      (in_y),
        .in_wr_en  (in_wr_en),
        .in_full   (in_full),
        .out_diff  (out_diff),
        .out_empty (out_empty),
        .out_rd_en (out_rd_en)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // x - y per lane is x plus the two's complement of y, carry dropped.
    function automatic vec3_t ref_diff(input vec3_t x, input vec3_t y);
        vec3_t                  r;
        logic [`VEC_LANE_WIDTH:0] sum;
        for (int i = 0; i < `VEC_LANES; i++) begin
            sum  = {1'b0, x[i]} + {1'b0, ~y[i]};
            sum  = sum + 1;
            r[i] = sum[`VEC_LANE_WIDTH-1:0];
        end
        return r;
    endfunction

    function automatic vec3_t random_vec();
        vec3_t v;
        for (int i = 0; i < `VEC_LANES; i++) begin
            v[i] = $random(seed);
        end
        return v;
    endfunction

    // true about three times in four.
    function automatic logic coin();
        int r;
        r = $random(seed);
        return r[1:0] != 2'b00;
    endfunction

    task automatic compare_vec(input string name, input vec3_t got, input vec3_t exp);
        checks++;
        for (int lane = 0; lane < `VEC_LANES; lane++) begin
            if (got[lane] !== exp[lane]) begin
                $display("ERROR %s lane %0d: got %h, expected %h", name, lane,
                         got[lane], exp[lane]);
                errors++;
            end
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic begin_test();
        test_mark = errors;
        tests++;
    endtask

    task automatic end_test(input string name);
        $display("test %0d %s: %0d errors", tests, name, errors - test_mark);
    endtask

    // called 1 ns after an edge, returns 1 ns after the write edge.
    task automatic push_vec(input vec3_t x, input vec3_t y);
        while (in_full) begin
            @(posedge clock);
            #1;
        end
        in_x     = x;
        in_y     = y;
        in_wr_en = 1'b1;
        @(posedge clock);
        #1;
        in_wr_en = 1'b0;
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        while (expected.size() != 0 && waited < drain_limit) begin
            out_rd_en = !out_empty;
            @(posedge clock);
            #1;
            waited++;
        end
        // keep reading a little longer to catch stray results.
        repeat (6) begin
            out_rd_en = !out_empty;
            @(posedge clock);
            #1;
        end
        out_rd_en = 1'b0;
        if (expected.size() != 0) begin
            $display("%0d expected results never came out of the DUT", expected.size());
            errors++;
            expected.delete();
        end
    endtask

    // accepted writes and reads are both seen here, half a cycle before their edge.
    always @(negedge clock) begin
        if (!reset) begin
            if (in_wr_en && !in_full) begin
                expected.push_back(ref_diff(in_x, in_y));
            end
            if (out_rd_en && !out_empty) begin
                if (expected.size() == 0) begin
                    $display("a result came out with no input to match it");
                    errors++;
                end else begin
                    head_v = expected.pop_front();
                    compare_vec("out_diff", out_diff, head_v);
                end
            end
        end
    end

    initial begin
        repeat (limit_cycles) @(posedge clock);
        $display("timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("test failed");
        $finish;
    end

    initial begin
        vec3_t x;
        vec3_t y;
        int    sent;
        int    accepted;

        seed      = 32'hba6b;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        test_mark = 0;
        reset     = 1'b1;
        in_x      = '0;
        in_y      = '0;
        in_wr_en  = 1'b0;
        out_rd_en = 1'b0;
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;

        begin_test();
        @(negedge clock);
        compare_bit("out_empty", out_empty, 1'b1);
        compare_bit("in_full", in_full, 1'b0);
        @(posedge clock);
        #1;
        end_test("reset state");

        begin_test();
        x[0] = 100;
        x[1] = -7;
        x[2] = 32'h12345678;
        y[0] = -250;
        y[1] = 5;
        y[2] = 32'h70000000;
        push_vec(x, y);
        @(negedge clock);
        compare_bit("out_empty", out_empty, 1'b1);
        @(negedge clock);
        compare_bit("out_empty", out_empty, 1'b1);
        @(negedge clock);
        compare_bit("out_empty", out_empty, 1'b0);
        @(posedge clock);
        #1;
        drain_results();
        end_test("single vector");

        begin_test();
        x[0] = 32'h80000000;
        x[1] = 32'h7fffffff;
        x[2] = 32'h00000000;
        y[0] = 1;
        y[1] = -1;
        y[2] = 32'h80000000;
        push_vec(x, y);
        x[0] = 0;
        x[1] = 32'h80000000;
        x[2] = 32'hffffffff;
        y[0] = 1;
        y[1] = 32'h7fffffff;
        y[2] = 32'h80000000;
        push_vec(x, y);
        drain_results();
        end_test("wraparound");

        begin_test();
        sent = 0;
        while (sent < stream_count) begin
            in_wr_en = 1'b0;
            if (coin() && !in_full) begin
                in_x     = random_vec();
                in_y     = random_vec();
                in_wr_en = 1'b1;
                sent++;
            end
            out_rd_en = coin() && !out_empty;
            @(posedge clock);
            #1;
        end
        in_wr_en = 1'b0;
        drain_results();
        end_test("random stream");

        begin_test();
        accepted = 0;
        while (accepted < fill_count) begin
            compare_bit("in_full", in_full, 1'b0);
            push_vec(random_vec(), random_vec());
            accepted++;
            repeat (2) @(posedge clock);
            #1;
        end
        compare_bit("in_full", in_full, 1'b1);
        // these writes meet a full operand FIFO and must vanish.
        repeat (4) begin
            compare_bit("in_full", in_full, 1'b1);
            in_x     = random_vec();
            in_y     = random_vec();
            in_wr_en = 1'b1;
            @(posedge clock);
            #1;
        end
        in_wr_en = 1'b0;
        drain_results();
        compare_bit("out_empty", out_empty, 1'b1);
        end_test("back-pressure fill");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+source
source/vec_sub_pkg.sv
source/operand_if.sv
source/show_ahead_fifo.sv
source/vec_sub_stage.sv
source/vec_sub_top.sv
bench/vec_sub_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the vector subtractor testbench with Verilator and runs it.

set -u

cd "$(dirname "$0")"

build_dir=obj_dir
sim_bin=vec_sub_sim
log_file=sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f build.f --top-module vec_sub_tb \
    -Mdir "$build_dir" -o "$sim_bin"
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "test failed" "$log_file"; then
    exit 1
fi

if ! grep -q "test passed" "$log_file"; then
    echo "simulation log holds no final verdict"
    exit 1
fi

exit 0
